//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - include_dirs:
      - .
    files:
      - cache_pkg.sv
      - cache.sv
      - mem_arbiter.sv
      - main_memory.sv
      - mem_subsystem.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mem_subsystem.sv

//--- cache.sv
// Direct-mapped write-through cache, no write allocate
// Serves one requester and issues line reads and word writes to the arbiter
`timescale 1ns/1ps
`include "cache_params.svh"

module cache import cache_pkg::*; (
  input  logic               clk,
  input  logic               rst,

  // Requester side
  input  logic               enable,
  input  logic               wr_en,
  input  logic [`ADDR_W-1:0] r_addr,
  input  logic [`ADDR_W-1:0] w_addr,
  input  logic [`WORD_W-1:0] data_in,
  output logic [`WORD_W-1:0] data_out,
  output logic               operation_complete,

  // Arbiter side
  output logic [`ADDR_W-1:0] mem_address,
  output logic [`WORD_W-1:0] mem_data_out,
  output logic               mem_wr_en,
  output logic               mem_req,
  input  logic [`LINE_W-1:0] mem_data_in,
  input  logic               mem_data_valid
);

  localparam int BYTE_W = $clog2(`WORD_W / 8);
  localparam int WSEL_W = `OFF_W - BYTE_W;

  cache_state_e state;

  // Line storage
  logic [`LINE_W-1:0]    line_data [`NUM_LINES];
  logic [`TAG_W-1:0]     line_tag  [`NUM_LINES];
  logic [`NUM_LINES-1:0] line_valid;

  // Operation captured at enable
  logic               req_wr;
  logic [`ADDR_W-1:0] req_addr;
  logic [`WORD_W-1:0] req_data;
  logic [`LINE_W-1:0] fill_line;

  logic [`IDX_W-1:0]  idx;
  logic [`TAG_W-1:0]  tag;
  logic [WSEL_W-1:0]  wsel;
  logic               hit;

  assign idx  = req_addr[`OFF_W +: `IDX_W];
  assign tag  = req_addr[`ADDR_W-1 -: `TAG_W];
  assign wsel = req_addr[BYTE_W +: WSEL_W];
  assign hit  = line_valid[idx] && (line_tag[idx] == tag);

  // One cycle in C_DONE per operation
  assign operation_complete = (state == C_DONE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= C_IDLE;
      mem_req    <= 1'b0;
      mem_wr_en  <= 1'b0;
      line_valid <= '0;
    end else begin
      mem_req <= 1'b0;
      case (state)
        C_IDLE: begin
          if (enable) begin
            state <= C_LOOKUP;
          end
        end
        C_LOOKUP: begin
          if (req_wr) begin
            // Every write goes through to memory
            mem_req   <= 1'b1;
            mem_wr_en <= 1'b1;
            state     <= C_REQ_BUS;
          end else if (hit) begin
            state <= C_DONE;
          end else begin
            mem_req   <= 1'b1;
            mem_wr_en <= 1'b0;
            state     <= C_REQ_BUS;
          end
        end
        C_REQ_BUS: begin
          if (mem_data_valid) begin
            mem_wr_en <= 1'b0;
            state     <= req_wr ? C_DONE : C_FILL;
          end
        end
        C_FILL: begin
          line_valid[idx] <= 1'b1;
          state           <= C_DONE;
        end
        C_DONE: begin
          state <= C_IDLE;
        end
        default: begin
          state <= C_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == C_IDLE && enable) begin
      req_wr   <= wr_en;
      req_addr <= wr_en ? w_addr : r_addr;
      req_data <= data_in;
    end

    if (state == C_LOOKUP) begin
      // Reads fetch the aligned line, writes carry the word address
      mem_address  <= req_wr ? req_addr : {req_addr[`ADDR_W-1:`OFF_W], {`OFF_W{1'b0}}};
      mem_data_out <= req_data;
      if (hit) begin
        if (req_wr) begin
          line_data[idx][wsel*`WORD_W +: `WORD_W] <= req_data;
        end else begin
          data_out <= line_data[idx][wsel*`WORD_W +: `WORD_W];
        end
      end
    end

    if (state == C_REQ_BUS && mem_data_valid && !req_wr) begin
      fill_line <= mem_data_in;
    end

    if (state == C_FILL) begin
      line_data[idx] <= fill_line;
      line_tag[idx]  <= tag;
      data_out       <= fill_line[wsel*`WORD_W +: `WORD_W];
    end
  end

  // No second request until the arbiter has answered the first
  assert property (@(posedge clk) disable iff (rst)
    mem_req |=> !mem_req until mem_data_valid);

  assert property (@(posedge clk) disable iff (rst)
    operation_complete |=> !operation_complete);

  // Requester only strobes an idle cache
  assert property (@(posedge clk) disable iff (rst)
    enable |-> state == C_IDLE);

endmodule

//--- cache_params.svh
// Shared width, geometry and timing macros for the two-port memory subsystem
// Addresses are scaled to 16 bits so the backing store fits in simulation
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Data word and cache line widths
`define WORD_W 64
`define LINE_W 512

// Byte address split into tag, index and line offset
`define ADDR_W 16
`define OFF_W 6
`define IDX_W 4
`define TAG_W (`ADDR_W - `IDX_W - `OFF_W)

// Direct-mapped geometry, one line per index
`define NUM_LINES 16

// Backing store size in lines
`define MEM_LINES 1024

// Cycles from a memory accept to its valid pulse
`define MEM_LATENCY 4

`endif

//--- cache_pkg.sv
// State types shared by the cache controller, the arbiter and the memory

package cache_pkg;

  // Cache controller
  typedef enum logic [2:0] {
    C_IDLE,
    C_LOOKUP,
    C_REQ_BUS,
    C_FILL,
    C_DONE
  } cache_state_e;

  // Arbiter, either waiting for a pending port or serving one
  typedef enum logic {
    ARB_IDLE,
    ARB_BUSY
  } arb_state_e;

  // Main memory, counting down its fixed latency in MEM_WAIT
  typedef enum logic {
    MEM_IDLE,
    MEM_WAIT
  } mem_state_e;

endpackage

//--- main_memory.sv
// Line-wide backing store with a fixed read and write latency
// Returns whole lines on reads and stores single words on writes
`timescale 1ns/1ps
`include "cache_params.svh"

module main_memory import cache_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               req,
  input  logic [`ADDR_W-1:0] addr,
  input  logic [`WORD_W-1:0] wdata,
  input  logic               wr_en,
  output logic [`LINE_W-1:0] rdata,
  output logic               valid
);

  localparam int MIDX_W = $clog2(`MEM_LINES);
  localparam int BYTE_W = $clog2(`WORD_W / 8);
  localparam int WSEL_W = `OFF_W - BYTE_W;
  localparam int CNT_W  = $clog2(`MEM_LATENCY + 1);

  // Contents start at zero
  logic [`LINE_W-1:0] store [`MEM_LINES] = '{default: '0};

  mem_state_e         state;
  logic [CNT_W-1:0]   cnt;
  logic [`ADDR_W-1:0] addr_q;
  logic [`WORD_W-1:0] wdata_q;
  logic               wr_q;

  logic [MIDX_W-1:0]  line_sel;
  logic [WSEL_W-1:0]  wsel;
  logic               done;

  assign line_sel = addr_q[`OFF_W +: MIDX_W];
  assign wsel     = addr_q[BYTE_W +: WSEL_W];
  assign done     = (state == MEM_WAIT) && (cnt == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= MEM_IDLE;
      cnt   <= '0;
      valid <= 1'b0;
    end else begin
      valid <= 1'b0;
      case (state)
        MEM_IDLE: begin
          if (req) begin
            cnt   <= CNT_W'(`MEM_LATENCY - 1);
            state <= MEM_WAIT;
          end
        end
        MEM_WAIT: begin
          if (cnt == '0) begin
            valid <= 1'b1;
            state <= MEM_IDLE;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: begin
          state <= MEM_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == MEM_IDLE && req) begin
      addr_q  <= addr;
      wdata_q <= wdata;
      wr_q    <= wr_en;
    end
    if (done) begin
      if (wr_q) begin
        store[line_sel][wsel*`WORD_W +: `WORD_W] <= wdata_q;
      end else begin
        rdata <= store[line_sel];
      end
    end
  end

  // Arbiter holds off until the previous access has answered
  assert property (@(posedge clk) disable iff (rst) req |-> state == MEM_IDLE);

endmodule

//--- mem_arbiter.sv
// Round-robin arbiter between two caches and one main memory
// Latches request pulses and steers the memory answer to the port it serves
`timescale 1ns/1ps
`include "cache_params.svh"

module mem_arbiter import cache_pkg::*; (
  input  logic               clk,
  input  logic               rst,

  // Port 0
  input  logic               req0,
  input  logic [`ADDR_W-1:0] addr0,
  input  logic [`WORD_W-1:0] wdata0,
  input  logic               wr_en0,
  output logic               valid0,

  // Port 1
  input  logic               req1,
  input  logic [`ADDR_W-1:0] addr1,
  input  logic [`WORD_W-1:0] wdata1,
  input  logic               wr_en1,
  output logic               valid1,

  // Shared line data for both ports
  output logic [`LINE_W-1:0] rdata,

  // Memory side
  output logic               mem_req,
  output logic [`ADDR_W-1:0] mem_addr,
  output logic [`WORD_W-1:0] mem_wdata,
  output logic               mem_wr_en,
  input  logic [`LINE_W-1:0] mem_rdata,
  input  logic               mem_valid
);

  arb_state_e state;

  logic               pend0;
  logic               pend1;
  logic [`ADDR_W-1:0] addr_q0;
  logic [`ADDR_W-1:0] addr_q1;
  logic [`WORD_W-1:0] wdata_q0;
  logic [`WORD_W-1:0] wdata_q1;
  logic               wr_q0;
  logic               wr_q1;

  logic               owner;
  logic               last;
  logic               grant;
  logic               pick;

  assign grant = (state == ARB_IDLE) && (pend0 || pend1);
  // On a tie the port served last yields
  assign pick  = (pend0 && pend1) ? ~last : pend1;

  assign rdata  = mem_rdata;
  assign valid0 = mem_valid && (state == ARB_BUSY) && !owner;
  assign valid1 = mem_valid && (state == ARB_BUSY) && owner;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ARB_IDLE;
      pend0     <= 1'b0;
      pend1     <= 1'b0;
      owner     <= 1'b0;
      last      <= 1'b1;
      mem_req   <= 1'b0;
      mem_wr_en <= 1'b0;
    end else begin
      mem_req <= 1'b0;
      if (grant && !pick) begin
        pend0 <= 1'b0;
      end
      if (grant && pick) begin
        pend1 <= 1'b0;
      end
      if (req0) begin
        pend0 <= 1'b1;
      end
      if (req1) begin
        pend1 <= 1'b1;
      end

      case (state)
        ARB_IDLE: begin
          if (grant) begin
            mem_req   <= 1'b1;
            mem_wr_en <= pick ? wr_q1 : wr_q0;
            owner     <= pick;
            last      <= pick;
            state     <= ARB_BUSY;
          end
        end
        ARB_BUSY: begin
          if (mem_valid) begin
            mem_wr_en <= 1'b0;
            state     <= ARB_IDLE;
          end
        end
        default: begin
          state <= ARB_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req0) begin
      addr_q0  <= addr0;
      wdata_q0 <= wdata0;
      wr_q0    <= wr_en0;
    end
    if (req1) begin
      addr_q1  <= addr1;
      wdata_q1 <= wdata1;
      wr_q1    <= wr_en1;
    end
    if (grant) begin
      mem_addr  <= pick ? addr_q1 : addr_q0;
      mem_wdata <= pick ? wdata_q1 : wdata_q0;
    end
  end

  assert property (@(posedge clk) disable iff (rst) !(valid0 && valid1));

  // A cache waits for its answer before it asks again
  assert property (@(posedge clk) disable iff (rst) req0 |-> !pend0);
  assert property (@(posedge clk) disable iff (rst) req1 |-> !pend1);

endmodule

//--- mem_subsystem.f
+incdir+.
cache_pkg.sv
cache.sv
mem_arbiter.sv
main_memory.sv
mem_subsystem.sv
tb_mem_subsystem.sv

//--- mem_subsystem.sv
// Two-requester memory subsystem
// Each port has its own cache, both share one arbiter and main memory
`timescale 1ns/1ps
`include "cache_params.svh"

module mem_subsystem (
  input  logic               clk,
  input  logic               rst,

  // Requester 0
  input  logic               enable0,
  input  logic               wr_en0,
  input  logic [`ADDR_W-1:0] r_addr0,
  input  logic [`ADDR_W-1:0] w_addr0,
  input  logic [`WORD_W-1:0] data_in0,
  output logic [`WORD_W-1:0] data_out0,
  output logic               operation_complete0,

  // Requester 1
  input  logic               enable1,
  input  logic               wr_en1,
  input  logic [`ADDR_W-1:0] r_addr1,
  input  logic [`ADDR_W-1:0] w_addr1,
  input  logic [`WORD_W-1:0] data_in1,
  output logic [`WORD_W-1:0] data_out1,
  output logic               operation_complete1
);

  // Cache to arbiter
  logic [`ADDR_W-1:0] c0_addr;
  logic [`WORD_W-1:0] c0_wdata;
  logic               c0_wr_en;
  logic               c0_req;
  logic               c0_valid;
  logic [`ADDR_W-1:0] c1_addr;
  logic [`WORD_W-1:0] c1_wdata;
  logic               c1_wr_en;
  logic               c1_req;
  logic               c1_valid;
  logic [`LINE_W-1:0] arb_rdata;

  // Arbiter to memory
  logic               mem_req;
  logic [`ADDR_W-1:0] mem_addr;
  logic [`WORD_W-1:0] mem_wdata;
  logic               mem_wr_en;
  logic [`LINE_W-1:0] mem_rdata;
  logic               mem_valid;

  cache u_cache0 (
    .clk                (clk),
    .rst                (rst),
    .enable             (enable0),
    .wr_en              (wr_en0),
    .r_addr             (r_addr0),
    .w_addr             (w_addr0),
    .data_in            (data_in0),
    .data_out           (data_out0),
    .operation_complete (operation_complete0),
    .mem_address        (c0_addr),
    .mem_data_out       (c0_wdata),
    .mem_wr_en          (c0_wr_en),
    .mem_req            (c0_req),
    .mem_data_in        (arb_rdata),
    .mem_data_valid     (c0_valid)
  );

  cache u_cache1 (
    .clk                (clk),
    .rst                (rst),
    .enable             (enable1),
    .wr_en              (wr_en1),
    .r_addr             (r_addr1),
    .w_addr             (w_addr1),
    .data_in            (data_in1),
    .data_out           (data_out1),
    .operation_complete (operation_complete1),
    .mem_address        (c1_addr),
    .mem_data_out       (c1_wdata),
    .mem_wr_en          (c1_wr_en),
    .mem_req            (c1_req),
    .mem_data_in        (arb_rdata),
    .mem_data_valid     (c1_valid)
  );

  mem_arbiter u_mem_arbiter (
    .clk       (clk),
    .rst       (rst),
    .req0      (c0_req),
    .addr0     (c0_addr),
    .wdata0    (c0_wdata),
    .wr_en0    (c0_wr_en),
    .valid0    (c0_valid),
    .req1      (c1_req),
    .addr1     (c1_addr),
    .wdata1    (c1_wdata),
    .wr_en1    (c1_wr_en),
    .valid1    (c1_valid),
    .rdata     (arb_rdata),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wr_en (mem_wr_en),
    .mem_rdata (mem_rdata),
    .mem_valid (mem_valid)
  );

  main_memory u_main_memory (
    .clk   (clk),
    .rst   (rst),
    .req   (mem_req),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .wr_en (mem_wr_en),
    .rdata (mem_rdata),
    .valid (mem_valid)
  );

endmodule

//--- tb_mem_subsystem.sv
// Testbench for the two-port memory subsystem
// Random traffic from both requesters, checked against a word-level memory model
`timescale 1ns/1ps
`include "cache_params.svh"

module tb_mem_subsystem;

  localparam int SEED       = 87573;
  localparam int NUM_OPS    = 2 + 50 + 3 + 3 + 8 + 2 * 40;
  localparam int MAX_CYCLES = NUM_OPS * (4 * `MEM_LATENCY + 10);

  logic               clk;
  logic               rst;
  logic               enable0;
  logic               wr_en0;
  logic [`ADDR_W-1:0] r_addr0;
  logic [`ADDR_W-1:0] w_addr0;
  logic [`WORD_W-1:0] data_in0;
  logic [`WORD_W-1:0] data_out0;
  logic               operation_complete0;
  logic               enable1;
  logic               wr_en1;
  logic [`ADDR_W-1:0] r_addr1;
  logic [`ADDR_W-1:0] w_addr1;
  logic [`WORD_W-1:0] data_in1;
  logic [`WORD_W-1:0] data_out1;
  logic               operation_complete1;

  // Word-level memory model and per-port cache tag model
  logic [`WORD_W-1:0] ref_mem [2**(`ADDR_W-3)];
  logic               model_valid [2][`NUM_LINES];
  logic [`TAG_W-1:0]  model_tag [2][`NUM_LINES];

  int errors;
  int test_num;
  int tests_passed;
  int tests_failed;

  mem_subsystem i_mem_subsystem (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Watchdog, limit scales with the number of operations
  initial begin
    int cycle_cnt;
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  function automatic logic [`ADDR_W-1:0] line_addr(input int port, input int line,
                                                  input int word);
    return {port[0], 9'(line), 3'(word), 3'b000};
  endfunction

  // Small window of lines per half so indices collide and lines get reused
  function automatic logic [`ADDR_W-1:0] rand_addr(input int port);
    return {port[0], 9'($urandom_range(23, 0)), 6'($urandom)};
  endfunction

  task automatic run_op(input int port, input logic wr, input logic [`ADDR_W-1:0] addr,
                        input logic [`WORD_W-1:0] wdata,
                        output logic [`WORD_W-1:0] rdata, output int cycles);
    logic done;
    logic [`ADDR_W-1:0] junk;
    junk = `ADDR_W'($urandom);
    @(posedge clk);
    if (port == 0) begin
      enable0  <= 1'b1;
      wr_en0   <= wr;
      r_addr0  <= wr ? junk : addr;
      w_addr0  <= wr ? addr : junk;
      data_in0 <= wdata;
    end else begin
      enable1  <= 1'b1;
      wr_en1   <= wr;
      r_addr1  <= wr ? junk : addr;
      w_addr1  <= wr ? addr : junk;
      data_in1 <= wdata;
    end
    // Edge where the cache samples enable
    @(posedge clk);
    if (port == 0) begin
      enable0 <= 1'b0;
    end else begin
      enable1 <= 1'b0;
    end
    cycles = 0;
    done   = 1'b0;
    while (!done) begin
      @(posedge clk);
      cycles++;
      done = (port == 0) ? operation_complete0 : operation_complete1;
    end
    rdata = (port == 0) ? data_out0 : data_out1;
  endtask

  // One operation, with data and latency checked against the model
  task automatic access(input int port, input logic wr, input logic [`ADDR_W-1:0] addr,
                        input logic [`WORD_W-1:0] wdata);
    logic [`IDX_W-1:0]  idx;
    logic [`TAG_W-1:0]  tag;
    logic               predict_hit;
    logic [`WORD_W-1:0] exp_data;
    logic [`WORD_W-1:0] got;
    int                 cycles;
    idx = addr[`OFF_W +: `IDX_W];
    tag = addr[`ADDR_W-1 -: `TAG_W];
    predict_hit = !wr && model_valid[port][idx] && (model_tag[port][idx] == tag);
    if (wr) begin
      ref_mem[addr[`ADDR_W-1:3]] = wdata;
    end
    exp_data = ref_mem[addr[`ADDR_W-1:3]];
    run_op(port, wr, addr, wdata, got, cycles);
    if (!wr) begin
      model_valid[port][idx] = 1'b1;
      model_tag[port][idx]   = tag;
      assert (got === exp_data) else begin
        $display("Mismatch at %0t: data_out%0d expected %h got %h (addr %h)",
                 $time, port, exp_data, got, addr);
        errors++;
      end
    end
    if (predict_hit) begin
      assert (cycles == 2) else begin
        $display("Mismatch at %0t: operation_complete%0d latency expected 2 got %0d",
                 $time, port, cycles);
        errors++;
      end
    end else begin
      assert (cycles > 2) else begin
        $display("Port %0d finished a memory access to %h in only %0d cycles at %0t",
                 port, addr, cycles, $time);
        errors++;
      end
    end
  endtask

  // Free-running traffic for one port, with idle gaps between operations
  task automatic port_traffic(input int port, input int n_ops);
    logic wr;
    for (int i = 0; i < n_ops; i++) begin
      wr = 1'($urandom_range(1, 0));
      access(port, wr, rand_addr(port), {$urandom, $urandom});
      repeat ($urandom_range(3, 0)) @(posedge clk);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    test_num++;
    if (errors == errors_before) begin
      tests_passed++;
      $display("Test %0d %s: ok", test_num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAILED with %0d errors", test_num, name, errors - errors_before);
    end
  endtask

  initial begin
    int                 err0;
    logic [`ADDR_W-1:0] addr;
    logic [`ADDR_W-1:0] addr_a;
    logic [`ADDR_W-1:0] addr_b;
    void'($urandom(SEED));
    errors       = 0;
    test_num     = 0;
    tests_passed = 0;
    tests_failed = 0;
    foreach (ref_mem[i]) ref_mem[i] = '0;
    foreach (model_valid[p, i]) model_valid[p][i] = 1'b0;
    rst      = 1'b1;
    enable0  = 1'b0;
    wr_en0   = 1'b0;
    r_addr0  = '0;
    w_addr0  = '0;
    data_in0 = '0;
    enable1  = 1'b0;
    wr_en1   = 1'b0;
    r_addr1  = '0;
    w_addr1  = '0;
    data_in1 = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // Quiet after reset, then cold reads return zero
    err0 = errors;
    repeat (10) begin
      @(posedge clk);
      assert (!operation_complete0) else begin
        $display("Mismatch at %0t: operation_complete0 expected 0 got 1", $time);
        errors++;
      end
      assert (!operation_complete1) else begin
        $display("Mismatch at %0t: operation_complete1 expected 0 got 1", $time);
        errors++;
      end
    end
    access(0, 1'b0, rand_addr(0), '0);
    access(1, 1'b0, rand_addr(1), '0);
    report_test("reset and cold reads", err0);

    // Port 0 alone, writes then reads, often in a line just filled
    err0 = errors;
    for (int i = 0; i < 20; i++) begin
      access(0, 1'b1, rand_addr(0), {$urandom, $urandom});
    end
    addr = rand_addr(0);
    for (int i = 0; i < 30; i++) begin
      if ($urandom_range(1, 0) == 1) begin
        addr = {addr[`ADDR_W-1:`OFF_W], 3'($urandom), 3'b000};
      end else begin
        addr = rand_addr(0);
      end
      access(0, 1'b0, addr, '0);
    end
    report_test("single port write and read", err0);

    // Repeated reads on a filled line
    err0 = errors;
    access(0, 1'b0, line_addr(0, 100, 0), '0);
    access(0, 1'b0, line_addr(0, 100, 0), '0);
    access(0, 1'b0, line_addr(0, 100, 7), '0);
    report_test("read hit timing", err0);

    // Write hit updates the cached word
    err0 = errors;
    access(0, 1'b0, line_addr(0, 70, 1), '0);
    access(0, 1'b1, line_addr(0, 70, 3), {$urandom, $urandom});
    access(0, 1'b0, line_addr(0, 70, 3), '0);
    report_test("write hit update", err0);

    // Two lines on index 8, read alternately
    err0 = errors;
    addr_a = line_addr(0, 40, 2);
    addr_b = line_addr(0, 56, 2);
    access(0, 1'b1, addr_a, {$urandom, $urandom});
    access(0, 1'b1, addr_b, {$urandom, $urandom});
    for (int i = 0; i < 6; i++) begin
      access(0, 1'b0, (i % 2 == 0) ? addr_a : addr_b, '0);
    end
    report_test("conflict eviction", err0);

    // Both ports at once, each in its own half
    err0 = errors;
    fork
      port_traffic(0, 40);
      port_traffic(1, 40);
    join
    report_test("two port traffic", err0);

    $display("Tests run: %0d, passed: %0d, failed: %0d", test_num, tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
